// ==== files.f ====
+incdir+hw
hw/mist_io_pkg.sv
hw/spi_byte_link.sv
hw/user_io_decoder.sv
hw/core_config_regs.sv
hw/mist_io_top.sv
test/mist_io_assert.sv
test/tb_mist_io.sv

// ==== hw/core_config_regs.sv ====
// config bytes apply one cycle after cfg_wr_en; values survive transactions until the next arst_n
`include "mist_io_params.svh"

module core_config_regs (
  input  logic                    clk_28,
  input  logic                    arst_n,
  input  mist_io_pkg::cfg_write_t cfg_wr,     // byte index and data
  input  logic                    cfg_wr_en,  // one cycle per byte
  output mist_io_pkg::core_cfg_t  core_cfg
);

  import mist_io_pkg::*;

  ////////////////////////////////////////////////////////////
  // reset defaults
  ////////////////////////////////////////////////////////////

  localparam logic [1:0] RST_FLAGS = `CFG_RESET_FLAGS;  // {joy_emu_en, scandoubler_off}

  localparam core_cfg_t CFG_RESET = '{
    cpu_config:      `CFG_RESET_CPU,
    memcfg:          `CFG_RESET_MEM,
    scandoubler_off: RST_FLAGS[0],
    joy_emu_en:      RST_FLAGS[1]
  };

  ////////////////////////////////////////////////////////////
  // byte-wise writes
  ////////////////////////////////////////////////////////////

  // byte 0 : cpu_config in low nibble, high nibble unused
  // byte 1 : joy_emu_en, scandoubler_off, memcfg[5:0]
  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      core_cfg <= CFG_RESET;
    end else if (cfg_wr_en) begin
      if (!cfg_wr.idx) begin
        core_cfg.cpu_config <= cfg_wr.data[3:0];
      end else begin
        core_cfg.joy_emu_en      <= cfg_wr.data[7];
        core_cfg.scandoubler_off <= cfg_wr.data[6];
        core_cfg.memcfg          <= cfg_wr.data[5:0];
      end
    end
  end

endmodule

// ==== hw/mist_io_params.svh ====
// fixed by the user_io SPI protocol and the core; keep CORE_TYPE in step with the controller firmware
`ifndef MIST_IO_PARAMS_SVH
`define MIST_IO_PARAMS_SVH

////////////////////////////////////////////////////////////
// core identification
////////////////////////////////////////////////////////////

`define CORE_TYPE        8'ha1    // minimig core id, sent during opcode byte

////////////////////////////////////////////////////////////
// configuration reset values
////////////////////////////////////////////////////////////

`define CFG_RESET_CPU    4'h0     // plain 68000, no cache, no fast kick
`define CFG_RESET_MEM    6'h05    // 1M chip, 512k slow, no fast
`define CFG_RESET_FLAGS  2'b11    // {joy_emu_en, scandoubler_off}

// pin synchronizer depth in clk_28, at least 2
`define SYNC_STAGES      2

`endif

// ==== hw/mist_io_pkg.sv ====
// shared types of the user_io block; encodings follow the controller firmware and must not move
package mist_io_pkg;

  ////////////////////////////////////////////////////////////
  // SPI opcodes, first byte of a transaction
  ////////////////////////////////////////////////////////////

  typedef enum logic [7:0] {
    op_joy0  = 8'h02,  // joystick 0, one data byte
    op_joy1  = 8'h03,  // joystick 1, one data byte
    op_mouse = 8'h04,  // buttons, dx, dy
    op_kbd   = 8'h05,  // one key code per data byte
    op_cfg   = 8'h06   // two config bytes
  } io_opcode_e;

  // decoder position inside a transaction
  typedef enum logic [2:0] {
    st_opcode,  // waiting for opcode byte
    st_data0,   // first data byte
    st_data1,   // second data byte
    st_data2,   // third data byte
    st_ignore   // drop bytes until select rises
  } dec_state_e;

  ////////////////////////////////////////////////////////////
  // keyboard / mouse event towards the core
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    km_mouse_x = 2'd0,  // dx, two's complement
    km_mouse_y = 2'd1,  // dy, two's complement
    km_kbd     = 2'd2   // raw key code
  } kbd_mouse_type_e;

  typedef struct packed {
    logic [7:0]      data;      // key code or motion
    kbd_mouse_type_e evt_type;  // what data means
  } kbd_mouse_evt_t;

  ////////////////////////////////////////////////////////////
  // core configuration
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0] cpu_config;       // cpu type, cache, turbo
    logic [5:0] memcfg;           // chip / slow / fast sizes
    logic       scandoubler_off;  // 15khz video out
    logic       joy_emu_en;       // keyboard joystick emulation
  } core_cfg_t;

  // one config byte from the decoder
  typedef struct packed {
    logic       idx;   // 0 cpu byte, 1 flags and memcfg byte
    logic [7:0] data;
  } cfg_write_t;

endpackage

// ==== hw/mist_io_top.sv ====
// pad tristate sits outside, spi_do_en drives it; clk_28 must run at least 4x spi_sck
module mist_io_top (
  input  logic                        clk_28,
  input  logic                        arst_n,
  input  logic                        spi_sck,
  input  logic                        spi_di,
  input  logic                        conf_data0,        // user_io select, active low
  input  logic                        spi_ss2,           // fpga core select
  input  logic                        spi_ss3,           // osd select
  input  logic                        core_sdo,          // core's own data out
  output logic                        spi_do,
  output logic                        spi_do_en,         // pad output enable
  output logic [5:0]                  joy0,
  output logic [5:0]                  joy1,
  output logic [2:0]                  mouse_buttons,
  output mist_io_pkg::kbd_mouse_evt_t kbd_mouse,
  output logic                        kbd_mouse_strobe,
  output mist_io_pkg::core_cfg_t      core_cfg
);

  import mist_io_pkg::*;

  logic [7:0] rx_byte;
  logic       byte_valid;
  logic       first_byte;
  logic       xfer_end;
  logic       user_miso;  // reply from user_io link
  cfg_write_t cfg_wr;
  logic       cfg_wr_en;
  logic       core_sel;   // core or osd addressed

  spi_byte_link u_link (
    .clk_28     (clk_28    ),
    .arst_n     (arst_n    ),
    .spi_sck    (spi_sck   ),
    .spi_di     (spi_di    ),
    .conf_data0 (conf_data0),
    .rx_byte    (rx_byte   ),
    .byte_valid (byte_valid),
    .first_byte (first_byte),
    .xfer_end   (xfer_end  ),
    .miso       (user_miso )
  );

  user_io_decoder u_dec (
    .clk_28           (clk_28          ),
    .arst_n           (arst_n          ),
    .rx_byte          (rx_byte         ),
    .byte_valid       (byte_valid      ),
    .first_byte       (first_byte      ),
    .xfer_end         (xfer_end        ),
    .joy0             (joy0            ),
    .joy1             (joy1            ),
    .mouse_buttons    (mouse_buttons   ),
    .kbd_mouse        (kbd_mouse       ),
    .kbd_mouse_strobe (kbd_mouse_strobe),
    .cfg_wr           (cfg_wr          ),
    .cfg_wr_en        (cfg_wr_en       )
  );

  core_config_regs u_cfg (
    .clk_28    (clk_28   ),
    .arst_n    (arst_n   ),
    .cfg_wr    (cfg_wr   ),
    .cfg_wr_en (cfg_wr_en),
    .core_cfg  (core_cfg )
  );

  ////////////////////////////////////////////////////////////
  // shared data-out select, user_io wins
  ////////////////////////////////////////////////////////////

  assign core_sel  = !spi_ss2 || !spi_ss3;
  assign spi_do    = !conf_data0 ? user_miso : (core_sel ? core_sdo : 1'b0);  // low when released
  assign spi_do_en = !conf_data0 || core_sel;

endmodule

// ==== hw/spi_byte_link.sv ====
// SPI mode 0, MSB first, oversampled; clk_28 must run at least 4x spi_sck, no sck while deselected
`include "mist_io_params.svh"

module spi_byte_link (
  input  logic       clk_28,
  input  logic       arst_n,
  input  logic       spi_sck,     // from io controller
  input  logic       spi_di,      // mosi
  input  logic       conf_data0,  // user_io select, active low
  output logic [7:0] rx_byte,     // last complete byte
  output logic       byte_valid,  // one cycle per byte
  output logic       first_byte,  // rx_byte is the opcode
  output logic       xfer_end,    // one cycle on select release
  output logic       miso         // reply bit towards the master
);

  // pin order in the synchronizer is {sck, di, ss}
  localparam logic [2:0] PIN_IDLE = 3'b001;  // sck low, select released

  ////////////////////////////////////////////////////////////
  // pin synchronizer and edge detection
  ////////////////////////////////////////////////////////////

  logic [`SYNC_STAGES-1:0][2:0] pin_sync;  // stage 0 is nearest the pins
  logic                         sck_s;
  logic                         di_s;
  logic                         ss_s;
  logic                         sck_q;     // edge register
  logic                         ss_q;
  logic                         sck_rise;
  logic                         sck_fall;
  logic                         ss_rise;

  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      pin_sync <= {`SYNC_STAGES{PIN_IDLE}};
      sck_q    <= 1'b0;
      ss_q     <= 1'b1;
    end else begin
      pin_sync <= {pin_sync[`SYNC_STAGES-2:0], {spi_sck, spi_di, conf_data0}};
      sck_q    <= sck_s;
      ss_q     <= ss_s;
    end
  end

  assign {sck_s, di_s, ss_s} = pin_sync[`SYNC_STAGES-1];

  assign sck_rise = sck_s & ~sck_q;  // master samples here too
  assign sck_fall = ~sck_s & sck_q;
  assign ss_rise  = ss_s & ~ss_q;

  ////////////////////////////////////////////////////////////
  // receive side
  ////////////////////////////////////////////////////////////

  logic [2:0] bit_cnt;   // bits seen in current byte
  logic       in_first;  // no byte yet in this transaction
  logic [6:0] rx_shift;  // bits 7..1 of the byte in flight

  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt    <= 3'd0;
      in_first   <= 1'b1;
      byte_valid <= 1'b0;
      first_byte <= 1'b0;
      xfer_end   <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      xfer_end   <= ss_rise;
      if (ss_s) begin
        bit_cnt  <= 3'd0;  // partial byte dropped here
        in_first <= 1'b1;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;  // wraps after bit 0
        if (bit_cnt == 3'd7) begin
          byte_valid <= 1'b1;
          first_byte <= in_first;
          in_first   <= 1'b0;
        end
      end
    end
  end

  // data path, qualified by byte_valid
  always_ff @(posedge clk_28) begin
    if (sck_rise && !ss_s) begin
      rx_shift <= {rx_shift[5:0], di_s};
      if (bit_cnt == 3'd7)
        rx_byte <= {rx_shift, di_s};  // bit 0 arrives last
    end
  end

  ////////////////////////////////////////////////////////////
  // transmit side
  ////////////////////////////////////////////////////////////

  logic [7:0] tx_shift;

  // held at the id while deselected, so it is in place when select falls
  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      tx_shift <= 8'h00;
    end else if (ss_s) begin
      tx_shift <= `CORE_TYPE;
    end else if (sck_fall) begin
      tx_shift <= {tx_shift[6:0], 1'b0};  // zeros after the id
    end
  end

  assign miso = tx_shift[7];

endmodule

// ==== hw/user_io_decoder.sv ====
// bytes after the opcode go to joystick, mouse, keyboard or config; no back-pressure on any output
module user_io_decoder (
  input  logic                        clk_28,
  input  logic                        arst_n,
  input  logic [7:0]                  rx_byte,
  input  logic                        byte_valid,        // one cycle per byte
  input  logic                        first_byte,        // rx_byte is the opcode
  input  logic                        xfer_end,          // select released
  output logic [5:0]                  joy0,              // {fire2, fire, up, down, left, right}
  output logic [5:0]                  joy1,
  output logic [2:0]                  mouse_buttons,
  output mist_io_pkg::kbd_mouse_evt_t kbd_mouse,
  output logic                        kbd_mouse_strobe,  // one cycle per event
  output mist_io_pkg::cfg_write_t     cfg_wr,
  output logic                        cfg_wr_en          // one cycle per config byte
);

  import mist_io_pkg::*;

  dec_state_e state;
  io_opcode_e opcode;  // latched on first byte
  io_opcode_e rx_op;   // incoming byte seen as opcode

  assign rx_op = io_opcode_e'(rx_byte);

  ////////////////////////////////////////////////////////////
  // transaction FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      state            <= st_opcode;
      opcode           <= op_joy0;
      joy0             <= 6'd0;
      joy1             <= 6'd0;
      mouse_buttons    <= 3'd0;
      kbd_mouse        <= '{data: 8'h00, evt_type: km_mouse_x};
      kbd_mouse_strobe <= 1'b0;
      cfg_wr           <= '{idx: 1'b0, data: 8'h00};
      cfg_wr_en        <= 1'b0;
    end else begin
      kbd_mouse_strobe <= 1'b0;  // strobes last one cycle
      cfg_wr_en        <= 1'b0;
      if (xfer_end) begin
        state <= st_opcode;  // also covers aborted bytes
      end else if (byte_valid && first_byte) begin
        opcode <= rx_op;
        case (rx_op)
          op_joy0, op_joy1, op_mouse, op_kbd, op_cfg: state <= st_data0;
          default:                                    state <= st_ignore;  // unknown
        endcase
      end else if (byte_valid) begin
        case (state)
          st_data0: begin
            case (opcode)
              op_joy0: begin
                joy0  <= rx_byte[5:0];  // top two bits unused
                state <= st_ignore;
              end
              op_joy1: begin
                joy1  <= rx_byte[5:0];
                state <= st_ignore;
              end
              op_mouse: begin
                mouse_buttons <= rx_byte[2:0];
                state         <= st_data1;
              end
              op_kbd: begin
                kbd_mouse        <= '{data: rx_byte, evt_type: km_kbd};
                kbd_mouse_strobe <= 1'b1;  // stay here, every byte is a key
              end
              op_cfg: begin
                cfg_wr    <= '{idx: 1'b0, data: rx_byte};
                cfg_wr_en <= 1'b1;
                state     <= st_data1;
              end
              default: state <= st_ignore;
            endcase
          end
          st_data1: begin
            case (opcode)
              op_mouse: begin
                kbd_mouse        <= '{data: rx_byte, evt_type: km_mouse_x};  // dx
                kbd_mouse_strobe <= 1'b1;
                state            <= st_data2;
              end
              op_cfg: begin
                cfg_wr    <= '{idx: 1'b1, data: rx_byte};
                cfg_wr_en <= 1'b1;
                state     <= st_ignore;  // later config bytes dropped
              end
              default: state <= st_ignore;
            endcase
          end
          st_data2: begin
            if (opcode == op_mouse) begin
              kbd_mouse        <= '{data: rx_byte, evt_type: km_mouse_y};  // dy
              kbd_mouse_strobe <= 1'b1;
            end
            state <= st_ignore;
          end
          default: state <= state;  // opcode wait or ignore
        endcase
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the testbench with Verilator from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f files.f --top-module tb_mist_io
./obj_dir/Vtb_mist_io 2>&1 | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi
echo "simulation finished without errors, see sim.log"

// ==== test/mist_io_assert.sv ====
// port-level checks bound into mist_io_top; reset values follow the params header
`include "mist_io_params.svh"

module mist_io_assert (
  input logic                   clk_28,
  input logic                   arst_n,
  input logic                   conf_data0,
  input logic                   spi_ss2,
  input logic                   spi_ss3,
  input logic                   spi_do_en,
  input logic                   kbd_mouse_strobe,
  input mist_io_pkg::core_cfg_t core_cfg
);
  timeunit 1ns;
  timeprecision 1ps;

  import mist_io_pkg::*;

  localparam logic [1:0] RST_FLAGS = `CFG_RESET_FLAGS;  // {joy_emu_en, scandoubler_off}
  localparam core_cfg_t  CFG_RESET =
    {`CFG_RESET_CPU, `CFG_RESET_MEM, RST_FLAGS[0], RST_FLAGS[1]};

  // events are single-cycle
  strobe_one_cycle: assert property (@(posedge clk_28) disable iff (!arst_n)
    kbd_mouse_strobe |=> !kbd_mouse_strobe)
    else $error("kbd_mouse_strobe high two cycles in a row");

  // pad released when nobody is selected
  do_en_released: assert property (@(posedge clk_28)
    (conf_data0 && spi_ss2 && spi_ss3) |-> !spi_do_en)
    else $error("spi_do_en high with all selects released");

  cfg_in_reset: assert property (@(posedge clk_28)
    !arst_n |-> (core_cfg == CFG_RESET))
    else $error("core_cfg differs from reset values during reset");

endmodule

bind mist_io_top mist_io_assert u_assert (.*);

// ==== test/mist_io_testdata.txt ====
# id sel nbytes b0 b1 b2 b3 joy0 joy1 buttons cfg nev ev0 ev1 ev2, all hex, expected state is cumulative
# sel 0 user_io, 1 user_io cut 4 bits into last byte, 2 ss2, 3 ss3, f none; ev is {type, data}
01 0 1 00 00 00 00 00 00 0 017 0 000 000 000
02 0 2 02 ff 00 00 3f 00 0 017 0 000 000 000
03 0 2 03 d5 00 00 3f 15 0 017 0 000 000 000
04 0 2 02 2a 00 00 2a 15 0 017 0 000 000 000
05 0 4 05 1c 9c 45 2a 15 0 017 3 21c 29c 245
06 0 2 05 f0 00 00 2a 15 0 017 1 2f0 000 000
07 0 4 04 05 10 f3 2a 15 5 017 2 010 1f3 000
08 0 4 04 ff 80 7f 2a 15 7 017 2 080 17f 000
09 0 3 06 3c 4a 00 2a 15 7 c2a 0 000 000 000
0a 0 4 06 05 95 77 2a 15 7 555 0 000 000 000
0b 1 2 06 ff 00 00 2a 15 7 555 0 000 000 000
0c 1 2 05 33 00 00 2a 15 7 555 0 000 000 000
0d 1 1 02 00 00 00 2a 15 7 555 0 000 000 000
0e 0 4 07 11 22 33 2a 15 7 555 0 000 000 000
0f 0 3 ff 02 3f 00 2a 15 7 555 0 000 000 000
10 2 2 a5 3c 00 00 2a 15 7 555 0 000 000 000
11 3 1 5a 00 00 00 2a 15 7 555 0 000 000 000
12 f 1 c3 00 00 00 2a 15 7 555 0 000 000 000
13 0 2 03 00 00 00 2a 00 7 555 0 000 000 000

// ==== test/tb_mist_io.sv ====
// reads test/mist_io_testdata.txt from the project root; sck runs at clk_28 / 8, mode 0 only
`include "mist_io_params.svh"

module tb_mist_io;
  timeunit 1ns;
  timeprecision 1ps;

  import mist_io_pkg::*;

  localparam int         SCK_HALF = 4;           // clk_28 cycles per sck phase
  localparam int         SETTLE   = 8;           // cycles after select release
  localparam logic [7:0] CORE_ID  = `CORE_TYPE;

  typedef struct packed {
    logic [7:0]  id;
    logic [3:0]  sel;      // select pattern
    logic [2:0]  nbytes;
    logic [31:0] bytes;    // b0 in top byte
    logic [5:0]  joy0;
    logic [5:0]  joy1;
    logic [2:0]  buttons;
    logic [11:0] cfg;      // core_cfg_t layout
    logic [1:0]  nev;
    logic [29:0] events;   // first event in top ten bits
  } test_vec_t;

  logic           clk_28 = 1'b0;
  logic           arst_n;
  logic           spi_sck;
  logic           spi_di;
  logic           conf_data0;
  logic           spi_ss2;
  logic           spi_ss3;
  logic           core_sdo;
  logic           spi_do;
  logic           spi_do_en;
  logic [5:0]     joy0;
  logic [5:0]     joy1;
  logic [2:0]     mouse_buttons;
  kbd_mouse_evt_t kbd_mouse;
  logic           kbd_mouse_strobe;
  core_cfg_t      core_cfg;

  test_vec_t  tests[$];
  logic [9:0] evq[$];       // {type, data} per strobe
  int         errs;
  int         failed_tests;
  int         cycles;
  int         cycle_limit;  // 0 until the data file is read

  mist_io_top uut (.*);

  always #5 clk_28 = ~clk_28;

  always @(posedge clk_28) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, transactions did not complete", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // event monitor, strobe is one cycle wide
  always @(negedge clk_28) begin
    if (arst_n && kbd_mouse_strobe)
      evq.push_back({kbd_mouse.evt_type, kbd_mouse.data});
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    errs++;
  endtask

  task automatic read_tests(output int total_bytes);
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [15];
    test_vec_t   vec;
    total_bytes = 0;
    fd = $fopen("test/mist_io_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/mist_io_testdata.txt");
      errs++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        cnt  = $fgets(line, fd);
        if (cnt > 1 && line.getc(0) != "#") begin  // skip blank and comment lines
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
          if (cnt != 15) begin
            $display("malformed data line: %s", line);
            errs++;
          end else begin
            vec.id      = f[0][7:0];
            vec.sel     = f[1][3:0];
            vec.nbytes  = f[2][2:0];
            vec.bytes   = {f[3][7:0], f[4][7:0], f[5][7:0], f[6][7:0]};
            vec.joy0    = f[7][5:0];
            vec.joy1    = f[8][5:0];
            vec.buttons = f[9][2:0];
            vec.cfg     = f[10][11:0];
            vec.nev     = f[11][1:0];
            vec.events  = {f[12][9:0], f[13][9:0], f[14][9:0]};
            tests.push_back(vec);
            total_bytes += int'(vec.nbytes);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // SPI master, one transaction per data line
  ////////////////////////////////////////////////////////////

  task automatic run_test(input test_vec_t vec);
    int          nbits;
    int          i;
    int          k;
    int          errs_before;
    logic        bit_val;
    logic        user_sel;  // conf_data0 transaction
    logic        core_sel;  // ss2 or ss3 transaction
    logic [31:0] data_sh;
    logic [7:0]  id_sh;
    logic [29:0] ev_sh;
    errs_before = errs;
    user_sel    = (vec.sel == 4'h0) || (vec.sel == 4'h1);
    core_sel    = (vec.sel == 4'h2) || (vec.sel == 4'h3);
    nbits       = 8 * int'(vec.nbytes);
    if (vec.sel == 4'h1)
      nbits = nbits - 4;  // select rises mid-byte
    data_sh = vec.bytes;
    id_sh   = CORE_ID;
    evq.delete();
    @(posedge clk_28);
    conf_data0 <= !user_sel;
    spi_ss2    <= (vec.sel != 4'h2);
    spi_ss3    <= (vec.sel != 4'h3);
    repeat (SCK_HALF) @(posedge clk_28);
    for (i = 0; i < nbits; i++) begin
      bit_val = data_sh[31];
      data_sh = data_sh << 1;
      @(posedge clk_28);
      spi_sck  <= 1'b0;
      spi_di   <= bit_val;
      core_sdo <= !bit_val;  // inverted, a wrong select shows on user_io
      repeat (SCK_HALF - 1) @(posedge clk_28);
      @(negedge clk_28);     // sample just before rising sck
      if ((user_sel || core_sel) && spi_do_en !== 1'b1)
        report_mismatch("spi_do_en", 32'(spi_do_en), 32'd1);
      if (!user_sel && !core_sel && spi_do_en !== 1'b0)
        report_mismatch("spi_do_en", 32'(spi_do_en), 32'd0);
      if (user_sel && i < 8 && spi_do !== id_sh[7])
        report_mismatch("spi_do", 32'(spi_do), 32'(id_sh[7]));  // core id on opcode byte
      if (user_sel && i >= 8 && spi_do !== 1'b0)
        report_mismatch("spi_do", 32'(spi_do), 32'd0);  // zeros after the id
      if (core_sel && spi_do !== !bit_val)
        report_mismatch("spi_do", 32'(spi_do), 32'(!bit_val));
      id_sh = id_sh << 1;
      @(posedge clk_28);
      spi_sck <= 1'b1;
      repeat (SCK_HALF - 1) @(posedge clk_28);
    end
    @(posedge clk_28);
    spi_sck <= 1'b0;
    repeat (SCK_HALF) @(posedge clk_28);
    conf_data0 <= 1'b1;
    spi_ss2    <= 1'b1;
    spi_ss3    <= 1'b1;
    repeat (SETTLE) @(posedge clk_28);
    @(negedge clk_28);
    if (joy0 !== vec.joy0)
      report_mismatch("joy0", 32'(joy0), 32'(vec.joy0));
    if (joy1 !== vec.joy1)
      report_mismatch("joy1", 32'(joy1), 32'(vec.joy1));
    if (mouse_buttons !== vec.buttons)
      report_mismatch("mouse_buttons", 32'(mouse_buttons), 32'(vec.buttons));
    if (core_cfg !== vec.cfg)
      report_mismatch("core_cfg", 32'(core_cfg), 32'(vec.cfg));
    if (evq.size() != int'(vec.nev))
      report_mismatch("kbd_mouse_strobe count", 32'(evq.size()), 32'(vec.nev));
    ev_sh = vec.events;
    for (k = 0; k < int'(vec.nev); k++) begin
      if (k < evq.size() && evq[k] !== ev_sh[29:20])
        report_mismatch("kbd_mouse", 32'(evq[k]), 32'(ev_sh[29:20]));
      ev_sh = ev_sh << 10;
    end
    if (errs == errs_before) begin
      $display("test %0h ok", vec.id);
    end else begin
      $display("test %0h failed", vec.id);
      failed_tests++;
    end
  endtask

  initial begin
    int total_bytes;
    int t;
    arst_n     = 1'b1;
    spi_sck    = 1'b0;
    spi_di     = 1'b0;
    conf_data0 = 1'b1;
    spi_ss2    = 1'b1;
    spi_ss3    = 1'b1;
    core_sdo   = 1'b0;
    read_tests(total_bytes);
    cycle_limit = total_bytes * 64 + 2000;
    #1 arst_n = 1'b0;  // async reset before first clock edge
    repeat (10) @(posedge clk_28);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk_28);
    if (tests.size() == 0) begin
      $display("no test vectors were read");
      errs++;
    end
    for (t = 0; t < tests.size(); t++)
      run_test(tests[t]);
    $display("%0d tests, %0d ok, %0d failed, %0d errors",
             tests.size(), tests.size() - failed_tests, failed_tests, errs);
    if (errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule
